// ==== eth_tx_patterns.txt ====
# name pre_byte interval_byte length padding_en crc_en clear_after_reads payload_hex fcs_hex
# payload_hex lists the bytes in send order, fcs_hex is the fcs value, sent lsb byte first
#
# a payload that ends in the bytes of its own crc register leaves that register at zero,
# so zero padding keeps it there and the fcs is ffffffff
check_digits    8 0  9 0 1 0 313233343536373839 cbf43926
abc_crc         8 1  3 0 1 0 616263 352441c2
abc_no_crc      7 1  3 0 0 0 616263 00000000
one_pre_byte    1 3  1 0 1 0 61 e8b7be43
pad_digits      8 2 13 1 1 0 313233343536373839d9c60b34 ffffffff
pad_abc         8 4  7 1 1 0 6162633dbedbca ffffffff
full_no_pad     8 0 60 1 1 0 54686520717569636b2062726f776e20666f78206a756d7073206f76657220746865206c617a7920646f67c65cb0be00000000000000000000000000 ffffffff
clear_mid       8 0  9 0 1 4 313233343536373839 cbf43926
after_clear     8 0  9 0 1 0 313233343536373839 cbf43926

// ==== verilog.f ====
+incdir+.
eth_tx_pkg.sv
eth_tx_segment_counter.sv
eth_tx_crc32.sv
eth_tx_frame_sequencer.sv
eth_tx_nibble_mux.sv
eth_mac_pe_tx.sv
tb_eth_mac_pe_tx.sv

// ==== tb_eth_mac_pe_tx.sv ====
`timescale 1ns/100ps
`include "eth_tx_defines.svh"

module tb_eth_mac_pe_tx;

localparam int MAX_TESTS = 16;
localparam int MAX_BYTES = 128;

logic pe_tx_clk;
logic pe_tx_rstn;
logic pe_tx_logic_clr;
logic tx_start;
logic tx_byte_re;
eth_tx_pkg::byte_t tx_byte_data;
eth_tx_pkg::pre_len_t r_pre_byte;
eth_tx_pkg::gap_len_t r_interval_byte;
eth_tx_pkg::byte_len_t r_tx_payload_byte_length;
logic r_hw_crc_en;
logic r_hw_padding_en;
eth_tx_pkg::nibble_t eth_tx;
eth_tx_pkg::nibble_t eth_tx_oen;
logic eth_tx_ctrl;
logic eth_tx_clk;
logic eth_tx_clk_oen;
logic tx_done;
logic int_status_tx_done;

// pattern table, one entry per file line
string t_name [MAX_TESTS];
string t_hex [MAX_TESTS];
int t_pre [MAX_TESTS];
int t_gap [MAX_TESTS];
int t_len [MAX_TESTS];
int t_pad [MAX_TESTS];
int t_crc [MAX_TESTS];
int t_clr [MAX_TESTS];
eth_tx_pkg::crc_t t_fcs [MAX_TESTS];
int num_tests;
int load_errs;
longint wd_ns;
logic wd_armed;

// state of the running test
string cur_name;
eth_tx_pkg::byte_t payload [MAX_BYTES];
eth_tx_pkg::nibble_t got_nib [$];
eth_tx_pkg::nibble_t exp_nib [$];
int test_errs;
int pass_cnt;
int fail_cnt;
logic capture_on;
logic frame_ended;
logic re_pending;
int cyc_cnt;
int last_drive;
int done_cycle;
int done_cnt;
int status_cycle;
int status_cnt;
int re_count;
int src_idx;

eth_mac_pe_tx DUT (
	.pe_tx_clk                (pe_tx_clk),
	.pe_tx_rstn               (pe_tx_rstn),
	.pe_tx_logic_clr          (pe_tx_logic_clr),
	.tx_start                 (tx_start),
	.tx_byte_re               (tx_byte_re),
	.tx_byte_data             (tx_byte_data),
	.r_pre_byte               (r_pre_byte),
	.r_interval_byte          (r_interval_byte),
	.r_tx_payload_byte_length (r_tx_payload_byte_length),
	.r_hw_crc_en              (r_hw_crc_en),
	.r_hw_padding_en          (r_hw_padding_en),
	.eth_tx                   (eth_tx),
	.eth_tx_oen               (eth_tx_oen),
	.eth_tx_ctrl              (eth_tx_ctrl),
	.eth_tx_clk               (eth_tx_clk),
	.eth_tx_clk_oen           (eth_tx_clk_oen),
	.tx_done                  (tx_done),
	.int_status_tx_done       (int_status_tx_done)
);

// 40 ns period
initial pe_tx_clk = 1'b0;
always #20 pe_tx_clk = ~pe_tx_clk;

// ==========================================================================
// compare tasks
// ==========================================================================

task automatic check_nibble(input string what, input eth_tx_pkg::nibble_t exp,
	input eth_tx_pkg::nibble_t act);
	if (exp !== act)
	begin
		$display("[ERROR] %s: %s expected %h actual %h", cur_name, what, exp, act);
		test_errs++;
	end
endtask

task automatic check_fcs(input eth_tx_pkg::crc_t exp, input eth_tx_pkg::crc_t act);
	if (exp !== act)
	begin
		$display("[ERROR] %s: fcs expected %h actual %h", cur_name, exp, act);
		test_errs++;
	end
endtask

task automatic check_count(input string what, input eth_tx_pkg::seg_cnt_t exp,
	input eth_tx_pkg::seg_cnt_t act);
	if (exp !== act)
	begin
		$display("[ERROR] %s: %s expected %0d actual %0d", cur_name, what, exp, act);
		test_errs++;
	end
endtask

task automatic check_flag(input string what, input logic exp, input logic act);
	if (exp !== act)
	begin
		$display("[ERROR] %s: %s expected %b actual %b", cur_name, what, exp, act);
		test_errs++;
	end
endtask

// inputs change 1 ns after the rising edge
task automatic to_drive_slot();
	@(posedge pe_tx_clk);
	#1;
endtask

// worst case frame length in cycles, padding counted as if always on
function automatic int frame_cycles(input int pre, input int gap, input int len);
	int body;
	body = (len > `ETH_TX_MIN_PAYLOAD) ? len : `ETH_TX_MIN_PAYLOAD;
	return 2 * (pre + body + `ETH_TX_CRC_BYTES + `ETH_TX_GAP_BASE + gap) + 10;
endfunction

// ==========================================================================
// pattern file
// ==========================================================================

task automatic load_patterns();
	int fd;
	int n;
	longint wd_cycles;
	string line;
	string name;
	string hex;
	int pre;
	int gap;
	int len;
	int pad;
	int crc;
	int clr;
	eth_tx_pkg::crc_t fcs;
	wd_cycles = 0;
	fd = $fopen("eth_tx_patterns.txt", "r");
	if (fd == 0)
	begin
		$display("the pattern file eth_tx_patterns.txt could not be opened");
		load_errs++;
	end
	else
	begin
		while (!$feof(fd))
		begin
			line = "";
			n = $fgets(line, fd);
			// skip comments and blank lines
			if ((n == 0) || (line.len() < 2) || (line.substr(0, 0) == "#"))
				continue;
			n = $sscanf(line, "%s %d %d %d %d %d %d %s %h",
				name, pre, gap, len, pad, crc, clr, hex, fcs);
			if ((n != 9) || (hex.len() != 2 * len) || (len > MAX_BYTES) ||
				(num_tests == MAX_TESTS))
			begin
				$display("pattern line could not be used: %s", line);
				load_errs++;
				continue;
			end
			t_name[num_tests] = name;
			t_hex[num_tests]  = hex;
			t_pre[num_tests]  = pre;
			t_gap[num_tests]  = gap;
			t_len[num_tests]  = len;
			t_pad[num_tests]  = pad;
			t_crc[num_tests]  = crc;
			t_clr[num_tests]  = clr;
			t_fcs[num_tests]  = fcs;
			// idle gap of up to 8 cycles plus the wait after done
			wd_cycles += frame_cycles(pre, gap, len) + 20;
			// a clear test also sits out one whole frame length
			if (clr > 0)
				wd_cycles += frame_cycles(pre, gap, len);
			num_tests++;
		end
		$fclose(fd);
	end
	wd_ns = (2 * wd_cycles + 200) * 40;
	wd_armed = 1'b1;
endtask

// expected nibble stream straight from the frame rules
task automatic build_expected(input int t);
	exp_nib.delete();
	for (int i = 0; i < 2 * t_pre[t] - 1; i++)
		exp_nib.push_back(`ETH_TX_PREAMBLE_NIBBLE);
	exp_nib.push_back(`ETH_TX_SFD_HIGH_NIBBLE);
	for (int i = 0; i < t_len[t]; i++)
	begin
		exp_nib.push_back(payload[i][3:0]);
		exp_nib.push_back(payload[i][7:4]);
	end
	if (t_pad[t] && (t_len[t] < `ETH_TX_MIN_PAYLOAD))
	begin
		for (int i = 0; i < 2 * (`ETH_TX_MIN_PAYLOAD - t_len[t]); i++)
			exp_nib.push_back(4'h0);
	end
	// fcs goes out lsb byte first, low nibble first
	if (t_crc[t])
	begin
		for (int k = 0; k < 2 * `ETH_TX_CRC_BYTES; k++)
			exp_nib.push_back(t_fcs[t][4 * k +: 4]);
	end
endtask

// ==========================================================================
// byte source and pin capture
// ==========================================================================

// strobes are seen mid cycle
always @(negedge pe_tx_clk)
begin
	if (tx_byte_re)
	begin
		re_pending = 1'b1;
		re_count++;
	end
	if (capture_on)
	begin
		cyc_cnt++;
		if (eth_tx_oen == 4'h0)
		begin
			if (frame_ended)
			begin
				$display("%s: the pins were driven again after the frame had ended", cur_name);
				test_errs++;
			end
			// low nibble rides the low clock half, high nibble the high half
			check_flag("eth_tx_clk", (got_nib.size() % 2) == 1, eth_tx_clk);
			check_flag("eth_tx_clk_oen", 1'b0, eth_tx_clk_oen);
			got_nib.push_back(eth_tx);
			last_drive = cyc_cnt;
		end
		else if (eth_tx_oen == 4'hf)
		begin
			if (got_nib.size() > 0)
				frame_ended = 1'b1;
		end
		else
		begin
			$display("%s: eth_tx_oen %h has its bits split", cur_name, eth_tx_oen);
			test_errs++;
		end
		check_flag("eth_tx_ctrl", (eth_tx_oen == 4'h0), eth_tx_ctrl);
		if (tx_done)
		begin
			done_cnt++;
			done_cycle = cyc_cnt;
		end
		if (int_status_tx_done)
		begin
			status_cnt++;
			status_cycle = cyc_cnt;
		end
	end
end

// byte lands in the cycle after its strobe
always @(posedge pe_tx_clk)
begin
	#1;
	if (re_pending)
	begin
		if (src_idx < MAX_BYTES)
			tx_byte_data = payload[src_idx];
		src_idx++;
		re_pending = 1'b0;
	end
end

// ==========================================================================
// one test
// ==========================================================================

task automatic run_test(input int t);
	int gap_cycles;
	int limit;
	int waited;
	int idle;
	int base;
	int k0;
	string pair;
	eth_tx_pkg::crc_t got_fcs;
	cur_name = t_name[t];
	test_errs = 0;
	for (int i = 0; i < MAX_BYTES; i++)
	begin
		pair = t_hex[t].substr(2 * i, 2 * i + 1);
		payload[i] = (i < t_len[t]) ? eth_tx_pkg::byte_t'(pair.atohex()) : eth_tx_pkg::byte_t'(i);
	end
	build_expected(t);
	gap_cycles = 2 * (`ETH_TX_GAP_BASE + t_gap[t]);
	limit = frame_cycles(t_pre[t], t_gap[t], t_len[t]);

	// configuration is stable well before the start
	to_drive_slot();
	r_pre_byte = eth_tx_pkg::pre_len_t'(t_pre[t]);
	r_interval_byte = eth_tx_pkg::gap_len_t'(t_gap[t]);
	r_tx_payload_byte_length = eth_tx_pkg::byte_len_t'(t_len[t]);
	r_hw_padding_en = (t_pad[t] != 0);
	r_hw_crc_en = (t_crc[t] != 0);
	got_nib.delete();
	frame_ended = 1'b0;
	done_cnt = 0;
	status_cnt = 0;
	cyc_cnt = 0;
	last_drive = 0;
	done_cycle = 0;
	status_cycle = 0;
	re_count = 0;
	src_idx = 0;
	capture_on = 1'b1;
	idle = 1 + ($urandom % 8);
	repeat (idle) to_drive_slot();
	tx_start = 1'b1;
	to_drive_slot();
	tx_start = 1'b0;

	waited = 0;
	if (t_clr[t] > 0)
	begin
		// clear in the middle of the payload
		while ((re_count < t_clr[t]) && (waited < limit))
		begin
			@(negedge pe_tx_clk);
			waited++;
		end
		if (waited >= limit)
		begin
			$display("%s: the payload reads never reached the clear point", cur_name);
			test_errs++;
		end
		to_drive_slot();
		pe_tx_logic_clr = 1'b1;
		to_drive_slot();
		pe_tx_logic_clr = 1'b0;
		@(negedge pe_tx_clk);
		check_nibble("eth_tx_oen after clear", 4'hf, eth_tx_oen);
		check_flag("eth_tx_ctrl after clear", 1'b0, eth_tx_ctrl);
		check_flag("eth_tx_clk_oen after clear", 1'b1, eth_tx_clk_oen);
		// long enough for an uncleared frame to reach its done
		repeat (limit) @(negedge pe_tx_clk);
		check_count("tx_done pulses", 0, eth_tx_pkg::seg_cnt_t'(done_cnt));
		check_count("int_status_tx_done pulses", 0, eth_tx_pkg::seg_cnt_t'(status_cnt));
	end
	else
	begin
		while ((done_cnt == 0) && (waited < limit))
		begin
			@(negedge pe_tx_clk);
			waited++;
		end
		if (done_cnt == 0)
		begin
			$display("%s: no tx_done within %0d cycles of the start", cur_name, limit);
			test_errs++;
			to_drive_slot();
			pe_tx_logic_clr = 1'b1;
			to_drive_slot();
			pe_tx_logic_clr = 1'b0;
		end
		// a second done pulse would show up here
		repeat (4) @(negedge pe_tx_clk);

		check_count("driven nibbles", eth_tx_pkg::seg_cnt_t'(exp_nib.size()),
			eth_tx_pkg::seg_cnt_t'(got_nib.size()));
		// report only the first wrong nibble
		base = test_errs;
		for (int i = 0; (i < exp_nib.size()) && (i < got_nib.size()) && (test_errs == base); i++)
			check_nibble($sformatf("nibble %0d", i), exp_nib[i], got_nib[i]);
		check_count("payload byte reads", eth_tx_pkg::seg_cnt_t'(t_len[t]),
			eth_tx_pkg::seg_cnt_t'(re_count));
		if (t_crc[t] && (got_nib.size() >= 8))
		begin
			k0 = got_nib.size() - 8;
			for (int k = 0; k < 4; k++)
				got_fcs[8 * k +: 8] = {got_nib[k0 + 2 * k + 1], got_nib[k0 + 2 * k]};
			check_fcs(t_fcs[t], got_fcs);
		end
		check_count("tx_done pulses", 1, eth_tx_pkg::seg_cnt_t'(done_cnt));
		if (done_cnt == 1)
			check_count("cycles from last nibble to tx_done", eth_tx_pkg::seg_cnt_t'(gap_cycles),
				eth_tx_pkg::seg_cnt_t'(done_cycle - last_drive));
		check_count("int_status_tx_done pulses", 1, eth_tx_pkg::seg_cnt_t'(status_cnt));
		if (status_cnt == 1)
			check_count("cycles from last nibble to int_status_tx_done",
				eth_tx_pkg::seg_cnt_t'(gap_cycles),
				eth_tx_pkg::seg_cnt_t'(status_cycle - last_drive));
		// pins back at rest once the frame is over
		check_flag("eth_tx_clk_oen at rest", 1'b1, eth_tx_clk_oen);
	end
	capture_on = 1'b0;

	if (test_errs == 0)
	begin
		$display("PASS  %s", cur_name);
		pass_cnt++;
	end
	else
	begin
		$display("FAIL  %s  (%0d errors)", cur_name, test_errs);
		fail_cnt++;
	end
endtask

// ==========================================================================
// main sequence and watchdog
// ==========================================================================

initial
begin
	pe_tx_rstn = 1'b0;
	pe_tx_logic_clr = 1'b0;
	tx_start = 1'b0;
	tx_byte_data = '0;
	r_pre_byte = '0;
	r_interval_byte = '0;
	r_tx_payload_byte_length = '0;
	r_hw_crc_en = 1'b0;
	r_hw_padding_en = 1'b0;
	capture_on = 1'b0;
	frame_ended = 1'b0;
	re_pending = 1'b0;
	re_count = 0;
	src_idx = 0;
	pass_cnt = 0;
	fail_cnt = 0;
	num_tests = 0;
	load_errs = 0;
	wd_armed = 1'b0;
	void'($urandom(20));
	load_patterns();
	// reset over two clock cycles
	repeat (2) @(posedge pe_tx_clk);
	#1;
	pe_tx_rstn = 1'b1;
	for (int t = 0; t < num_tests; t++)
		run_test(t);
	$display("tests %0d, passed %0d, failed %0d, bad pattern lines %0d",
		num_tests, pass_cnt, fail_cnt, load_errs);
	if ((fail_cnt == 0) && (load_errs == 0) && (num_tests > 0))
		$display("TEST OK");
	else
		$display("TEST FAILED");
	$finish;
end

// limit from the summed frame lengths
initial
begin
	wait (wd_armed);
	#(wd_ns);
	$display("timeout: the run did not finish within %0d ns", wd_ns);
	$display("TEST FAILED");
	$finish;
end

endmodule

// ==== eth_mac_pe_tx.sv ====
`timescale 1ns/100ps
`include "eth_tx_defines.svh"

module eth_mac_pe_tx (
	input  logic                  pe_tx_clk,
	input  logic                  pe_tx_rstn,
	input  logic                  pe_tx_logic_clr,
	input  logic                  tx_start,
	// byte source
	output logic                  tx_byte_re,
	input  eth_tx_pkg::byte_t     tx_byte_data,
	// configuration, stable over a frame
	input  eth_tx_pkg::pre_len_t  r_pre_byte,
	input  eth_tx_pkg::gap_len_t  r_interval_byte,
	input  eth_tx_pkg::byte_len_t r_tx_payload_byte_length,
	input  logic                  r_hw_crc_en,
	input  logic                  r_hw_padding_en,
	// rgmii pins
	output eth_tx_pkg::nibble_t   eth_tx,
	output eth_tx_pkg::nibble_t   eth_tx_oen,
	output logic                  eth_tx_ctrl,
	output logic                  eth_tx_clk,
	output logic                  eth_tx_clk_oen,
	// status
	output logic                  tx_done,
	output logic                  int_status_tx_done
);

eth_tx_pkg::frame_state_e state;
logic phase;
logic [`ETH_TX_SEG_NUM-1:0] seg_step;
logic [`ETH_TX_SEG_NUM-1:0] seg_clear;
logic [`ETH_TX_SEG_NUM-1:0] seg_last;
eth_tx_pkg::seg_cnt_t [`ETH_TX_SEG_NUM-1:0] seg_limit;
eth_tx_pkg::seg_cnt_t [`ETH_TX_SEG_NUM-1:0] seg_count;
logic crc_en;
logic crc_clear;
eth_tx_pkg::byte_t crc_data;
eth_tx_pkg::crc_t crc_fcs;

// ==========================================================================
// frame sequencer
// ==========================================================================

eth_tx_frame_sequencer u_sequencer (
	.pe_tx_clk                (pe_tx_clk),
	.pe_tx_rstn               (pe_tx_rstn),
	.pe_tx_logic_clr          (pe_tx_logic_clr),
	.tx_start                 (tx_start),
	.r_pre_byte               (r_pre_byte),
	.r_interval_byte          (r_interval_byte),
	.r_tx_payload_byte_length (r_tx_payload_byte_length),
	.r_hw_crc_en              (r_hw_crc_en),
	.r_hw_padding_en          (r_hw_padding_en),
	.seg_last                 (seg_last),
	.state                    (state),
	.phase                    (phase),
	.seg_step                 (seg_step),
	.seg_clear                (seg_clear),
	.seg_limit                (seg_limit),
	.tx_byte_re               (tx_byte_re),
	.crc_en                   (crc_en),
	.crc_clear                (crc_clear),
	.tx_done                  (tx_done),
	.int_status_tx_done       (int_status_tx_done)
);

// preamble, payload, padding, crc, gap
for (genvar i = 0; i < `ETH_TX_SEG_NUM; i++)
begin : g_seg
	eth_tx_segment_counter u_seg_cnt (
		.pe_tx_clk  (pe_tx_clk),
		.pe_tx_rstn (pe_tx_rstn),
		.seg_step   (seg_step[i]),
		.seg_clear  (seg_clear[i]),
		.seg_limit  (seg_limit[i]),
		.seg_count  (seg_count[i]),
		.seg_last   (seg_last[i])
	);
end

// ==========================================================================
// fcs and pins
// ==========================================================================

// padding bytes fold in as zero
assign crc_data = (state == eth_tx_pkg::PAYLOAD) ? tx_byte_data : '0;

eth_tx_crc32 u_crc32 (
	.pe_tx_clk  (pe_tx_clk),
	.pe_tx_rstn (pe_tx_rstn),
	.crc_clear  (crc_clear),
	.crc_en     (crc_en),
	.crc_data   (crc_data),
	.crc_fcs    (crc_fcs)
);

eth_tx_nibble_mux u_nibble_mux (
	.pe_tx_clk       (pe_tx_clk),
	.pe_tx_rstn      (pe_tx_rstn),
	.pe_tx_logic_clr (pe_tx_logic_clr),
	.state           (state),
	.phase           (phase),
	.preamble_last   (seg_last[`ETH_TX_SEG_PREAMBLE]),
	.crc_count       (seg_count[`ETH_TX_SEG_CRC]),
	.tx_byte_data    (tx_byte_data),
	.crc_fcs         (crc_fcs),
	.eth_tx          (eth_tx),
	.eth_tx_oen      (eth_tx_oen),
	.eth_tx_ctrl     (eth_tx_ctrl),
	.eth_tx_clk      (eth_tx_clk),
	.eth_tx_clk_oen  (eth_tx_clk_oen)
);

endmodule

// ==== eth_tx_nibble_mux.sv ====
`timescale 1ns/100ps
`include "eth_tx_defines.svh"

module eth_tx_nibble_mux (
	input  logic                     pe_tx_clk,
	input  logic                     pe_tx_rstn,
	input  logic                     pe_tx_logic_clr,
	input  eth_tx_pkg::frame_state_e state,
	input  logic                     phase,
	input  logic                     preamble_last,
	input  eth_tx_pkg::seg_cnt_t     crc_count,
	input  eth_tx_pkg::byte_t        tx_byte_data,
	input  eth_tx_pkg::crc_t         crc_fcs,
	output eth_tx_pkg::nibble_t      eth_tx,
	output eth_tx_pkg::nibble_t      eth_tx_oen,
	output logic                     eth_tx_ctrl,
	output logic                     eth_tx_clk,
	output logic                     eth_tx_clk_oen
);

eth_tx_pkg::byte_t fcs_byte;
eth_tx_pkg::nibble_t nib;
logic drive;
logic run;

// ==========================================================================
// nibble select
// ==========================================================================

// fcs byte picked by the crc segment count, lsb byte first
assign fcs_byte = crc_fcs[{crc_count[1:0], 3'b000} +: 8];

always_comb
begin
	nib   = '0;
	drive = 1'b0;
	case (state)
	eth_tx_pkg::PREAMBLE:
	begin
		drive = 1'b1;
		// sfd is 0xd5, so only its high nibble differs
		if (phase && preamble_last)
			nib = `ETH_TX_SFD_HIGH_NIBBLE;
		else
			nib = `ETH_TX_PREAMBLE_NIBBLE;
	end
	eth_tx_pkg::PAYLOAD:
	begin
		drive = 1'b1;
		// low nibble first
		nib = phase ? tx_byte_data[7:4] : tx_byte_data[3:0];
	end
	eth_tx_pkg::PADDING:
	begin
		drive = 1'b1;
	end
	eth_tx_pkg::CRC:
	begin
		drive = 1'b1;
		nib = phase ? fcs_byte[7:4] : fcs_byte[3:0];
	end
	default:
	begin
		// idle, gap and end leave the pins released
		drive = 1'b0;
	end
	endcase
end

// clock keeps running through the gap
assign run = drive || (state == eth_tx_pkg::GAP);

// ==========================================================================
// pin registers
// ==========================================================================

// one cycle behind the sequencer phase
always_ff @(posedge pe_tx_clk or negedge pe_tx_rstn)
begin
	if (!pe_tx_rstn)
	begin
		eth_tx         <= '0;
		eth_tx_oen     <= '1;
		eth_tx_ctrl    <= 1'b0;
		eth_tx_clk     <= 1'b0;
		eth_tx_clk_oen <= 1'b1;
	end
	else if (pe_tx_logic_clr)
	begin
		// release at once
		eth_tx         <= '0;
		eth_tx_oen     <= '1;
		eth_tx_ctrl    <= 1'b0;
		eth_tx_clk     <= 1'b0;
		eth_tx_clk_oen <= 1'b1;
	end
	else
	begin
		eth_tx         <= nib;
		eth_tx_oen     <= {4{~drive}};
		// ctrl is a level over every driven nibble
		eth_tx_ctrl    <= drive;
		// low on phase 0, high on phase 1
		eth_tx_clk     <= run && phase;
		eth_tx_clk_oen <= !run;
	end
end

endmodule

// ==== eth_tx_frame_sequencer.sv ====
`timescale 1ns/100ps
`include "eth_tx_defines.svh"

module eth_tx_frame_sequencer (
	input  logic                                       pe_tx_clk,
	input  logic                                       pe_tx_rstn,
	input  logic                                       pe_tx_logic_clr,
	input  logic                                       tx_start,
	input  eth_tx_pkg::pre_len_t                       r_pre_byte,
	input  eth_tx_pkg::gap_len_t                       r_interval_byte,
	input  eth_tx_pkg::byte_len_t                      r_tx_payload_byte_length,
	input  logic                                       r_hw_crc_en,
	input  logic                                       r_hw_padding_en,
	input  logic [`ETH_TX_SEG_NUM-1:0]                 seg_last,
	output eth_tx_pkg::frame_state_e                   state,
	output logic                                       phase,
	output logic [`ETH_TX_SEG_NUM-1:0]                 seg_step,
	output logic [`ETH_TX_SEG_NUM-1:0]                 seg_clear,
	output eth_tx_pkg::seg_cnt_t [`ETH_TX_SEG_NUM-1:0] seg_limit,
	output logic                                       tx_byte_re,
	output logic                                       crc_en,
	output logic                                       crc_clear,
	output logic                                       tx_done,
	output logic                                       int_status_tx_done
);

eth_tx_pkg::frame_state_e next_state;
eth_tx_pkg::seg_cnt_t pad_len;
logic [`ETH_TX_SEG_NUM-1:0] seg_active;
logic [`ETH_TX_SEG_NUM-1:0] seg_busy;
logic last_byte;
logic byte_edge;

// first non-empty segment at or above index from
// gap is never empty so it is the fallback
function automatic eth_tx_pkg::frame_state_e first_seg(
	input logic [`ETH_TX_SEG_NUM-1:0] busy,
	input int from
);
	eth_tx_pkg::frame_state_e st;
	st = eth_tx_pkg::GAP;
	// walk down so the lowest hit wins
	for (int i = `ETH_TX_SEG_NUM - 1; i >= 0; i--)
	begin
		if ((i >= from) && busy[i])
			st = eth_tx_pkg::frame_state_e'(3'(i + 1));
	end
	return st;
endfunction

// ==========================================================================
// segment limits
// ==========================================================================

// pad short payloads up to 60 bytes
assign pad_len = (r_hw_padding_en && (r_tx_payload_byte_length < `ETH_TX_MIN_PAYLOAD)) ?
	eth_tx_pkg::seg_cnt_t'(`ETH_TX_MIN_PAYLOAD) - r_tx_payload_byte_length : '0;

always_comb
begin
	seg_limit[`ETH_TX_SEG_PREAMBLE] = eth_tx_pkg::seg_cnt_t'(r_pre_byte);
	seg_limit[`ETH_TX_SEG_PAYLOAD]  = r_tx_payload_byte_length;
	seg_limit[`ETH_TX_SEG_PADDING]  = pad_len;
	seg_limit[`ETH_TX_SEG_CRC]      = r_hw_crc_en ? eth_tx_pkg::seg_cnt_t'(`ETH_TX_CRC_BYTES) : '0;
	// gap is 5 plus the configured bytes
	seg_limit[`ETH_TX_SEG_GAP]      = eth_tx_pkg::seg_cnt_t'(`ETH_TX_GAP_BASE) +
		eth_tx_pkg::seg_cnt_t'(r_interval_byte);
end

// which segments exist and which one runs
always_comb
begin
	for (int i = 0; i < `ETH_TX_SEG_NUM; i++)
	begin
		seg_busy[i]   = (seg_limit[i] != '0);
		seg_active[i] = (state == eth_tx_pkg::frame_state_e'(3'(i + 1)));
	end
end

// final byte end of the running segment
assign last_byte = phase && |(seg_active & seg_last);

// ==========================================================================
// frame fsm
// ==========================================================================

always_comb
begin
	next_state = state;
	if (pe_tx_logic_clr)
		next_state = eth_tx_pkg::IDLE;
	else
	begin
		case (state)
		eth_tx_pkg::IDLE:
			if (tx_start)
				next_state = first_seg(seg_busy, 0);
		eth_tx_pkg::GAP:
			if (last_byte)
				next_state = eth_tx_pkg::END;
		eth_tx_pkg::END:
			next_state = eth_tx_pkg::IDLE;
		default:
			// state value equals the index of the following segment
			if (last_byte)
				next_state = first_seg(seg_busy, int'(state));
		endcase
	end
end

// phase 0 low nibble, phase 1 high nibble and byte end
always_ff @(posedge pe_tx_clk or negedge pe_tx_rstn)
begin
	if (!pe_tx_rstn)
	begin
		state <= eth_tx_pkg::IDLE;
		phase <= 1'b0;
	end
	else
	begin
		state <= next_state;
		phase <= (|seg_active) && !pe_tx_logic_clr && !phase;
	end
end

// ==========================================================================
// strobes to counters, byte source and crc
// ==========================================================================

assign seg_step  = seg_active & {`ETH_TX_SEG_NUM{phase}};
assign seg_clear = ~seg_active;

// read one byte ahead, data lands in the next phase 0
assign byte_edge  = phase || (state == eth_tx_pkg::IDLE);
assign tx_byte_re = byte_edge && (next_state == eth_tx_pkg::PAYLOAD);

// fold each payload or padding byte once, in its phase 0
assign crc_en = r_hw_crc_en && !phase &&
	(seg_active[`ETH_TX_SEG_PAYLOAD] || seg_active[`ETH_TX_SEG_PADDING]);
assign crc_clear = pe_tx_logic_clr || ((state == eth_tx_pkg::IDLE) && tx_start);

assign tx_done            = (state == eth_tx_pkg::END);
assign int_status_tx_done = (state == eth_tx_pkg::END);

// padding without fcs is not a legal frame setup
a_pad_needs_crc: assert property (@(posedge pe_tx_clk) disable iff (!pe_tx_rstn)
	(tx_start && r_hw_padding_en) |-> r_hw_crc_en);

// start only while the engine rests
a_start_in_idle: assert property (@(posedge pe_tx_clk) disable iff (!pe_tx_rstn)
	tx_start |-> (state == eth_tx_pkg::IDLE));

endmodule

// ==== eth_tx_crc32.sv ====
`timescale 1ns/100ps
`include "eth_tx_defines.svh"

module eth_tx_crc32 (
	input  logic              pe_tx_clk,
	input  logic              pe_tx_rstn,
	input  logic              crc_clear,
	input  logic              crc_en,
	input  eth_tx_pkg::byte_t crc_data,
	output eth_tx_pkg::crc_t  crc_fcs
);

eth_tx_pkg::crc_t crc_q;
eth_tx_pkg::crc_t crc_next;

// ==========================================================================
// byte-wide reflected crc-32
// ==========================================================================

// one byte, lsb first, eight shift steps
function automatic eth_tx_pkg::crc_t crc_fold(
	input eth_tx_pkg::crc_t crc,
	input eth_tx_pkg::byte_t data
);
	eth_tx_pkg::crc_t c;
	c = crc ^ {24'h000000, data};
	for (int i = 0; i < 8; i++)
	begin
		if (c[0])
			c = (c >> 1) ^ `ETH_TX_CRC_POLY;
		else
			c = c >> 1;
	end
	return c;
endfunction

assign crc_next = crc_fold(crc_q, crc_data);

// seeded with all ones per frame
always_ff @(posedge pe_tx_clk or negedge pe_tx_rstn)
begin
	if (!pe_tx_rstn)
	begin
		crc_q <= `ETH_TX_CRC_INIT;
	end
	else if (crc_clear)
	begin
		crc_q <= `ETH_TX_CRC_INIT;
	end
	else if (crc_en)
	begin
		crc_q <= crc_next;
	end
end

// fcs is the complement, byte 0 goes out first
assign crc_fcs = ~crc_q;

endmodule

// ==== eth_tx_segment_counter.sv ====
`timescale 1ns/100ps

module eth_tx_segment_counter (
	input  logic                 pe_tx_clk,
	input  logic                 pe_tx_rstn,
	input  logic                 seg_step,
	input  logic                 seg_clear,
	input  eth_tx_pkg::seg_cnt_t seg_limit,
	output eth_tx_pkg::seg_cnt_t seg_count,
	output logic                 seg_last
);

// ==========================================================================
// byte counter
// ==========================================================================

// count is the index of the byte now on the wire
// holds on the final byte until the segment is left
always_ff @(posedge pe_tx_clk or negedge pe_tx_rstn)
begin
	if (!pe_tx_rstn)
	begin
		seg_count <= '0;
	end
	else if (seg_clear)
	begin
		seg_count <= '0;
	end
	else if (seg_step && !seg_last)
	begin
		seg_count <= seg_count + 1'b1;
	end
end

// final byte flag, quiet while the segment is idle
assign seg_last = !seg_clear && (seg_count == seg_limit - 1'b1);

// sequencer never steps an empty segment or one past its end
a_within_limit: assert property (@(posedge pe_tx_clk) disable iff (!pe_tx_rstn)
	seg_step |-> (seg_count < seg_limit));

endmodule

// ==== eth_tx_pkg.sv ====
package eth_tx_pkg;

// ==========================================================================
// frame state machine
// ==========================================================================

// segment states are numbered so that state minus one is the segment index
typedef enum logic [2:0] {
	IDLE     = 3'd0,
	PREAMBLE = 3'd1,
	PAYLOAD  = 3'd2,
	PADDING  = 3'd3,
	CRC      = 3'd4,
	GAP      = 3'd5,
	END      = 3'd6
} frame_state_e;

// ==========================================================================
// widths
// ==========================================================================

// data path
typedef logic [7:0]  byte_t;
typedef logic [3:0]  nibble_t;
typedef logic [31:0] crc_t;

// payload length from the descriptor
typedef logic [11:0] byte_len_t;
// byte count of one segment
typedef logic [11:0] seg_cnt_t;

// preamble bytes including sfd
typedef logic [3:0]  pre_len_t;
// extra gap bytes on top of the fixed five
typedef logic [5:0]  gap_len_t;

endpackage

// ==== eth_tx_defines.svh ====
`ifndef ETH_TX_DEFINES_SVH
`define ETH_TX_DEFINES_SVH

// ==========================================================================
// segment indices, order of the segments on the wire
// ==========================================================================

`define ETH_TX_SEG_PREAMBLE     0
`define ETH_TX_SEG_PAYLOAD      1
`define ETH_TX_SEG_PADDING      2
`define ETH_TX_SEG_CRC          3
`define ETH_TX_SEG_GAP          4
`define ETH_TX_SEG_NUM          5

// ==========================================================================
// byte counts
// ==========================================================================

// payload target of hardware padding
`define ETH_TX_MIN_PAYLOAD      60
`define ETH_TX_CRC_BYTES        4
// fixed part of the inter-frame gap, in bytes
`define ETH_TX_GAP_BASE         5

// nibble codes of preamble and sfd
`define ETH_TX_PREAMBLE_NIBBLE  4'h5
`define ETH_TX_SFD_HIGH_NIBBLE  4'hd

// reflected crc-32 polynomial and seed
`define ETH_TX_CRC_POLY         32'hedb88320
`define ETH_TX_CRC_INIT         32'hffffffff

`endif
